// File: list.f
+incdir+hdl
hdl/ctrl_pkg.sv
hdl/ctrl_ifs.sv
hdl/opcode_decoder.sv
hdl/funct_decoder.sv
hdl/control_sequencer.sv
hdl/control_unit.sv
test/tb_control_unit.sv

// File: test/tb_control_unit.sv
// control unit testbench
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_macros.svh"

module tb_control_unit;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 2;
    localparam int RST_CYCLES  = 16;
    localparam int N_INSTR     = 400;
    localparam int WATCHDOG_NS = (N_INSTR * 4 * 3 + RST_CYCLES + 16) * CLK_PERIOD;

    // opcode table with R-format and REGIMM weighted up and five unknown codes last
    localparam logic [5:0] OPC_TABLE [0:31] = '{
        `OPC_RTYPE, `OPC_REGIMM, `OPC_J, `OPC_JAL, `OPC_BEQ, `OPC_BNE, `OPC_BLEZ,
        `OPC_BGTZ, `OPC_ADDIU, `OPC_SLTI, `OPC_SLTIU, `OPC_ANDI, `OPC_ORI, `OPC_XORI,
        `OPC_LUI, `OPC_LB, `OPC_LH, `OPC_LW, `OPC_LBU, `OPC_LHU, `OPC_SB, `OPC_SH,
        `OPC_SW, `OPC_RTYPE, `OPC_RTYPE, `OPC_RTYPE, `OPC_REGIMM,
        6'b001000, 6'b100010, 6'b100110, 6'b010000, 6'b111111
    };

    // funct table ending in nine codes that decode to nothing
    localparam logic [5:0] FN_TABLE [0:31] = '{
        `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV, `FN_JR, `FN_JALR,
        `FN_MFHI, `FN_MTHI, `FN_MFLO, `FN_MTLO, `FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU,
        `FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_SLT, `FN_SLTU,
        6'b000001, 6'b000101, 6'b001100, 6'b001101, 6'b100000, 6'b100010,
        6'b100111, 6'b111111, 6'b010100
    };

    localparam logic [4:0] RT_TABLE [0:3] = '{`RT_BLTZAL, `RT_BGEZAL, 5'b00000, 5'b00001};

    logic        clk;
    logic        rst;
    logic        run;
    logic [31:0] instr;
    logic        waitrequest;
    logic [1:0]  addr_align;

    logic [3:0]  state;
    logic [3:0]  byteenable;
    logic [3:0]  alu_op;
    logic [1:0]  div_mult_op;
    logic [2:0]  extend_op;
    logic        bytewrite, halfwrite, alu_src, signed_imm, jump, branch;
    logic        memread, memwrite, regdst, memtoreg, regwrite, inwrite;
    logic        pctoadd, pcwrite, regtojump, div_mult_en, div_mult_signed;
    logic        hitoreg, lotoreg, link, loadimmed;

    logic [31:0] lfsr_state;
    int          value_errs;
    int          other_errs;

    // reference model
    logic [3:0]  exp_state;
    logic [5:0]  opc;
    logic [4:0]  rt_f;
    logic [5:0]  fn;
    logic        is_rtype, is_store, reads_mem, link_rt, jr_like;
    logic        dec_wb, dec_md, dec_jump, dec_link, dec_alu_src, dec_branch, dec_regdst;
    logic [1:0]  dec_md_op;
    logic [3:0]  dec_alu_op;
    logic [2:0]  dec_ext;
    logic [3:0]  dec_be;
    logic        in_exec1, in_exec2;

    // strobe bit order is {memread, memwrite, regwrite, inwrite, pctoadd,
    // pcwrite, div_mult_en}
    logic [6:0]  act_strobe, exp_strobe;
    logic [3:0]  act_flow, exp_flow;
    logic [6:0]  act_alu, exp_alu;
    logic [10:0] act_mem, exp_mem;
    logic [4:0]  act_md, exp_md;

    control_unit u_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = next_lfsr(lfsr_state);
        end
        return bits;
    endfunction

    function automatic logic [31:0] random_instr();
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sh;
        logic [5:0] fc;
        op = OPC_TABLE[5'(take_bits(5))];
        rs = 5'(take_bits(5));
        if (take_bits(1) == 1) begin
            rt = RT_TABLE[2'(take_bits(2))];   // favour the REGIMM link forms
        end else begin
            rt = 5'(take_bits(5));
        end
        rd = 5'(take_bits(5));
        sh = 5'(take_bits(5));
        fc = FN_TABLE[5'(take_bits(5))];
        return {op, rs, rt, rd, sh, fc};
    endfunction

    task automatic report_mismatch(input string check, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        value_errs++;
        $display("[FAIL] %s: expected %h, actual %h at %0t ns", check, exp_v, act_v, $time);
    endtask

    task automatic report_failure(input string what);
        other_errs++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    // one instruction from fetch back to fetch with stalls about one cycle in four
    task automatic run_instruction();
        logic left_fetch;
        left_fetch = 1'b0;
        instr      = random_instr();
        while (!(left_fetch && state == `ST_FETCH)) begin
            waitrequest = take_bits(2) == 3;
            addr_align  = 2'(take_bits(2));
            @(posedge clk);
            #DRIVE_DLY;
            if (state != `ST_FETCH) begin
                left_fetch = 1'b1;
            end
        end
    endtask

    assign opc       = instr[31:26];
    assign rt_f      = instr[20:16];
    assign fn        = instr[5:0];
    assign is_rtype  = opc == `OPC_RTYPE;
    assign is_store  = opc inside {`OPC_SB, `OPC_SH, `OPC_SW};
    assign reads_mem = opc inside {`OPC_LB, `OPC_LBU, `OPC_LH, `OPC_LHU, `OPC_LW, `OPC_LUI};
    assign link_rt   = opc == `OPC_REGIMM && rt_f inside {`RT_BLTZAL, `RT_BGEZAL};
    assign jr_like   = is_rtype && fn inside {`FN_JR, `FN_JALR};
    assign dec_jump  = opc inside {`OPC_J, `OPC_JAL} || jr_like;
    assign dec_link  = opc == `OPC_JAL || (is_rtype && fn == `FN_JALR) || link_rt;
    assign dec_md    = is_rtype && fn inside {`FN_MTHI, `FN_MTLO, `FN_MULT, `FN_MULTU,
                                              `FN_DIV, `FN_DIVU};
    assign dec_wb    = (is_rtype && fn inside {`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR,
                                               `FN_SLT, `FN_SLTU, `FN_SLL, `FN_SRL, `FN_SRA,
                                               `FN_SLLV, `FN_SRLV, `FN_SRAV, `FN_MFHI,
                                               `FN_MFLO, `FN_JALR})
                     || opc inside {`OPC_ADDIU, `OPC_SLTI, `OPC_SLTIU, `OPC_ANDI, `OPC_ORI,
                                    `OPC_XORI, `OPC_LUI, `OPC_JAL}
                     || (reads_mem && opc != `OPC_LUI) || link_rt;
    assign dec_alu_src = opc inside {`OPC_ADDIU, `OPC_SLTI, `OPC_SLTIU, `OPC_ANDI, `OPC_ORI,
                                     `OPC_XORI, `OPC_LUI, `OPC_BGTZ, `OPC_BLEZ, `OPC_REGIMM}
                       || reads_mem || is_store;
    assign dec_branch = opc inside {`OPC_BEQ, `OPC_BNE, `OPC_BGTZ, `OPC_BLEZ, `OPC_REGIMM};
    assign dec_regdst = is_rtype || is_store;
    assign dec_md_op  = !is_rtype ? 2'b00 :
                        fn == `FN_MTLO ? 2'b01 :
                        fn inside {`FN_MULT, `FN_MULTU} ? 2'b10 :
                        fn inside {`FN_DIV, `FN_DIVU} ? 2'b11 : 2'b00;
    assign dec_be     = opc == `OPC_SB ? 4'b1000 >> addr_align :
                        opc == `OPC_SH ? 4'b1100 >> addr_align : 4'b1111;
    assign in_exec1   = exp_state == `ST_EXEC1;
    assign in_exec2   = exp_state == `ST_EXEC2;

    always_comb begin
        case (opc)
            `OPC_RTYPE:  dec_alu_op = `ALU_FUNCT;
            `OPC_SLTI:   dec_alu_op = `ALU_SLT;
            `OPC_SLTIU:  dec_alu_op = `ALU_SLTU;
            `OPC_ANDI:   dec_alu_op = `ALU_AND;
            `OPC_ORI:    dec_alu_op = `ALU_OR;
            `OPC_XORI:   dec_alu_op = `ALU_XOR;
            `OPC_BEQ:    dec_alu_op = `ALU_SUB_EQ;
            `OPC_BNE:    dec_alu_op = `ALU_NE;
            `OPC_BGTZ:   dec_alu_op = `ALU_GTZ;
            `OPC_BLEZ:   dec_alu_op = `ALU_LEZ;
            `OPC_REGIMM: dec_alu_op = `ALU_LTZ;
            default:     dec_alu_op = `ALU_ADD;
        endcase
        case (opc)
            `OPC_LB:  dec_ext = `EXT_BYTE_S;
            `OPC_LBU: dec_ext = `EXT_BYTE_U;
            `OPC_LH:  dec_ext = `EXT_HALF_S;
            `OPC_LHU: dec_ext = `EXT_HALF_U;
            default:  dec_ext = `EXT_NONE;
        endcase
    end

    always_comb begin
        exp_strobe = '0;
        exp_flow   = '0;
        exp_alu    = {`ALU_ADD, 3'b000};
        exp_mem    = {4'b1111, 4'b0000, `EXT_NONE};
        exp_md     = '0;
        case (exp_state)
            `ST_FETCH:  exp_strobe = 7'b1000100;     // memread and pctoadd
            `ST_DECODE: exp_strobe = 7'b0001100;     // inwrite and pctoadd
            `ST_EXEC1, `ST_EXEC2: begin
                exp_strobe = {in_exec1 & reads_mem, in_exec2 & is_store, in_exec2 & dec_wb,
                              2'b00, in_exec2 & ~waitrequest, in_exec1 & dec_md};
                exp_flow   = {dec_jump, dec_branch, dec_link, jr_like};
                exp_alu    = {dec_alu_op, dec_alu_src, opc == `OPC_SLTI, dec_regdst};
                exp_mem    = {dec_be, opc == `OPC_SB, opc inside {`OPC_SB, `OPC_SH},
                              opc == `OPC_LW, opc == `OPC_LUI, dec_ext};
                exp_md     = {is_rtype && fn inside {`FN_MULT, `FN_DIV}, dec_md_op,
                              is_rtype && fn == `FN_MFHI, is_rtype && fn == `FN_MFLO};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exp_state <= `ST_HALT;
        end else begin
            case (exp_state)
                `ST_HALT:   exp_state <= run ? `ST_FETCH : `ST_HALT;
                `ST_FETCH:  exp_state <= waitrequest ? `ST_FETCH : `ST_DECODE;
                `ST_DECODE: exp_state <= `ST_EXEC1;
                `ST_EXEC1:  exp_state <= (reads_mem && waitrequest) ? `ST_EXEC1 : `ST_EXEC2;
                `ST_EXEC2:  exp_state <= waitrequest ? `ST_EXEC2 : `ST_FETCH;
                default:    exp_state <= `ST_HALT;
            endcase
        end
    end

    assign act_strobe = {memread, memwrite, regwrite, inwrite, pctoadd, pcwrite, div_mult_en};
    assign act_flow   = {jump, branch, link, regtojump};
    assign act_alu    = {alu_op, alu_src, signed_imm, regdst};
    assign act_mem    = {byteenable, bytewrite, halfwrite, memtoreg, loadimmed, extend_op};
    assign act_md     = {div_mult_signed, div_mult_op, hitoreg, lotoreg};

    a_state: assert property (@(posedge clk) disable iff (rst) state == exp_state)
        else report_mismatch("state", $sampled(exp_state), $sampled(state));
    a_strobes: assert property (@(posedge clk) disable iff (rst) act_strobe == exp_strobe)
        else report_mismatch("strobes", $sampled(exp_strobe), $sampled(act_strobe));
    a_flow: assert property (@(posedge clk) disable iff (rst) act_flow == exp_flow)
        else report_mismatch("jump/branch/link", $sampled(exp_flow), $sampled(act_flow));
    a_alu: assert property (@(posedge clk) disable iff (rst) act_alu == exp_alu)
        else report_mismatch("alu controls", $sampled(exp_alu), $sampled(act_alu));
    a_mem: assert property (@(posedge clk) disable iff (rst) act_mem == exp_mem)
        else report_mismatch("memory controls", $sampled(exp_mem), $sampled(act_mem));
    a_md: assert property (@(posedge clk) disable iff (rst) act_md == exp_md)
        else report_mismatch("mult/div and hi/lo", $sampled(exp_md), $sampled(act_md));

    a_decode_once: assert property (@(posedge clk) disable iff (rst) inwrite |=> !inwrite)
        else report_failure("inwrite stayed high for more than one cycle");
    a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
        (state == `ST_FETCH && waitrequest) |=> state == `ST_FETCH)
        else report_failure("fetch was left while waitrequest was high");
    a_halt_hold: assert property (@(posedge clk) disable iff (rst)
        (state == `ST_HALT && !run) |=> state == `ST_HALT)
        else report_failure("halt was left while run was low");
    a_run_start: assert property (@(posedge clk) disable iff (rst)
        (state == `ST_HALT && run) |=> state == `ST_FETCH)
        else report_failure("no move to fetch one cycle after run");

    initial begin
        lfsr_state  = 32'd87834;
        value_errs  = 0;
        other_errs  = 0;
        clk         = 1'b0;
        rst         = 1'b1;
        run         = 1'b0;
        instr       = '0;
        waitrequest = 1'b0;
        addr_align  = 2'b00;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        repeat (4) begin                      // sit in halt with run low
            @(posedge clk);
            #DRIVE_DLY;
        end
        run = 1'b1;
        while (state != `ST_FETCH) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        repeat (N_INSTR) run_instruction();
        repeat (4) @(posedge clk);
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // about three times the stall-free length of the run
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the instructions did not complete", WATCHDOG_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/control_unit.sv
// control unit top level
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_macros.svh"

module control_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    run,
    input  logic [`CTRL_WORD_W-1:0] instr,
    input  logic                    waitrequest,
    input  logic [1:0]              addr_align,
    output ctrl_pkg::state_t        state,
    output logic [3:0]              byteenable,
    output logic                    bytewrite,
    output logic                    halfwrite,
    output ctrl_pkg::alu_op_t       alu_op,
    output logic                    alu_src,
    output logic                    signed_imm,
    output logic                    jump,
    output logic                    branch,
    output logic                    memread,
    output logic                    memwrite,
    output logic                    regdst,
    output logic                    memtoreg,
    output logic                    regwrite,
    output logic                    inwrite,
    output logic                    pctoadd,
    output logic                    pcwrite,
    output logic                    regtojump,
    output logic                    div_mult_en,
    output logic                    div_mult_signed,
    output ctrl_pkg::md_op_t        div_mult_op,
    output logic                    hitoreg,
    output logic                    lotoreg,
    output logic                    link,
    output logic                    loadimmed,
    output ctrl_pkg::ext_op_t       extend_op
);

    ctrl_pkg::instr_word_t word;

    assign word = ctrl_pkg::instr_word_t'(instr);

    opc_dec_if u_opc_if ();
    fn_dec_if  u_fn_if ();

    opcode_decoder u_opc_dec (
        .opcode (word.i.opcode),
        .dec_o  (u_opc_if)
    );

    funct_decoder u_fn_dec (
        .funct (word.r.funct),
        .rt    (word.i.rt),      // REGIMM link select
        .dec_o (u_fn_if)
    );

    control_sequencer u_seq (
        .clk             (clk),
        .rst             (rst),
        .run             (run),
        .waitrequest     (waitrequest),
        .addr_align      (addr_align),
        .opc_i           (u_opc_if),
        .fn_i            (u_fn_if),
        .state           (state),
        .byteenable      (byteenable),
        .bytewrite       (bytewrite),
        .halfwrite       (halfwrite),
        .alu_op          (alu_op),
        .alu_src         (alu_src),
        .signed_imm      (signed_imm),
        .jump            (jump),
        .branch          (branch),
        .memread         (memread),
        .memwrite        (memwrite),
        .regdst          (regdst),
        .memtoreg        (memtoreg),
        .regwrite        (regwrite),
        .inwrite         (inwrite),
        .pctoadd         (pctoadd),
        .pcwrite         (pcwrite),
        .regtojump       (regtojump),
        .div_mult_en     (div_mult_en),
        .div_mult_signed (div_mult_signed),
        .div_mult_op     (div_mult_op),
        .hitoreg         (hitoreg),
        .lotoreg         (lotoreg),
        .link            (link),
        .loadimmed       (loadimmed),
        .extend_op       (extend_op)
    );

endmodule

`default_nettype wire

// File: hdl/control_sequencer.sv
// multicycle control sequencer
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_macros.svh"

module control_sequencer (
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    input  logic               waitrequest,
    input  logic [1:0]         addr_align,
    opc_dec_if.seq             opc_i,
    fn_dec_if.seq              fn_i,
    output ctrl_pkg::state_t   state,
    output logic [3:0]         byteenable,
    output logic               bytewrite,
    output logic               halfwrite,
    output ctrl_pkg::alu_op_t  alu_op,
    output logic               alu_src,
    output logic               signed_imm,
    output logic               jump,
    output logic               branch,
    output logic               memread,
    output logic               memwrite,
    output logic               regdst,
    output logic               memtoreg,
    output logic               regwrite,
    output logic               inwrite,
    output logic               pctoadd,
    output logic               pcwrite,
    output logic               regtojump,
    output logic               div_mult_en,
    output logic               div_mult_signed,
    output ctrl_pkg::md_op_t   div_mult_op,
    output logic               hitoreg,
    output logic               lotoreg,
    output logic               link,
    output logic               loadimmed,
    output ctrl_pkg::ext_op_t  extend_op
);

    logic exec1;
    logic exec2;
    logic mem_rd_op;   // load or LUI reads memory in exec1
    logic rtype_fn;    // funct flags only count for R-format

    assign exec1     = state == `ST_EXEC1;
    assign exec2     = state == `ST_EXEC2;
    assign mem_rd_op = opc_i.is_load | opc_i.loadimmed;
    assign rtype_fn  = opc_i.is_rtype;
    assign pcwrite   = exec2 & ~waitrequest;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= `ST_HALT;
        end else begin
            case (state)
                `ST_HALT:   if (run) state <= `ST_FETCH;
                `ST_FETCH:  if (!waitrequest) state <= `ST_DECODE;
                `ST_DECODE: state <= `ST_EXEC1;
                `ST_EXEC1:  if (!(mem_rd_op && waitrequest)) state <= `ST_EXEC2;
                `ST_EXEC2:  if (!waitrequest) state <= `ST_FETCH;
                default:    state <= `ST_HALT;
            endcase
        end
    end

    always_comb begin
        byteenable      = 4'b1111;
        bytewrite       = 1'b0;
        halfwrite       = 1'b0;
        alu_op          = ctrl_pkg::ALU_ADD;
        alu_src         = 1'b0;
        signed_imm      = 1'b0;
        jump            = 1'b0;
        branch          = 1'b0;
        memread         = 1'b0;
        memwrite        = 1'b0;
        regdst          = 1'b0;
        memtoreg        = 1'b0;
        regwrite        = 1'b0;
        inwrite         = 1'b0;
        pctoadd         = 1'b0;
        regtojump       = 1'b0;
        div_mult_en     = 1'b0;
        div_mult_signed = 1'b0;
        div_mult_op     = ctrl_pkg::MD_MTHI;
        hitoreg         = 1'b0;
        lotoreg         = 1'b0;
        link            = 1'b0;
        loadimmed       = 1'b0;
        extend_op       = ctrl_pkg::EXT_NONE;

        if (state == `ST_FETCH) begin
            memread = 1'b1;                                  // PC to memory address
            pctoadd = 1'b1;
        end else if (state == `ST_DECODE) begin
            inwrite = 1'b1;                                  // latch the instruction
            pctoadd = 1'b1;
        end else if (exec1 || exec2) begin
            if (opc_i.store_byte) begin
                byteenable = 4'b1000 >> addr_align;
            end else if (opc_i.store_half) begin
                byteenable = 4'b1100 >> addr_align;
            end
            bytewrite       = opc_i.store_byte;
            halfwrite       = opc_i.store_byte | opc_i.store_half;
            alu_op          = opc_i.alu_op;
            alu_src         = opc_i.alu_src;
            signed_imm      = opc_i.signed_imm;
            branch          = opc_i.branch;
            regdst          = opc_i.regdst;
            memtoreg        = opc_i.memtoreg;
            loadimmed       = opc_i.loadimmed;
            extend_op       = opc_i.extend_op;
            jump            = opc_i.jump | (rtype_fn & fn_i.regjump);
            regtojump       = rtype_fn & fn_i.regjump;
            link            = opc_i.link | (rtype_fn & fn_i.jalr)
                            | (opc_i.is_regimm & fn_i.branchlink);
            hitoreg         = rtype_fn & fn_i.hitoreg;
            lotoreg         = rtype_fn & fn_i.lotoreg;
            div_mult_signed = rtype_fn & fn_i.md_signed;
            div_mult_op     = rtype_fn ? fn_i.md_op : ctrl_pkg::MD_MTHI;
            div_mult_en     = exec1 & rtype_fn & fn_i.mult_div;   // one exec1 pulse
            memread         = exec1 & mem_rd_op;
            memwrite        = exec2 & opc_i.is_store;
            regwrite        = exec2 & ((rtype_fn & fn_i.arith) | opc_i.writes_reg
                                       | (opc_i.is_regimm & fn_i.branchlink));
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {`ST_HALT, `ST_FETCH, `ST_DECODE, `ST_EXEC1, `ST_EXEC2})
        else $error("illegal state %0d", state);

    // no opcode decodes as both a memory read and a store
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(mem_rd_op && opc_i.is_store))
        else $error("instruction decoded as both memory read and store");

    a_exec2_hold: assert property (@(posedge clk) disable iff (rst)
        (state == `ST_EXEC2 && waitrequest) |=> state == `ST_EXEC2)
        else $error("exec2 left under waitrequest");

endmodule

`default_nettype wire

// File: hdl/funct_decoder.sv
// funct and REGIMM decoder
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_macros.svh"

module funct_decoder (
    input  logic [`CTRL_FN_W-1:0]  funct,
    input  logic [`CTRL_REG_W-1:0] rt,
    fn_dec_if.dec                  dec_o
);

    always_comb begin
        // functs that write rd in exec2
        dec_o.arith = funct inside {`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR,
                                    `FN_SLT, `FN_SLTU, `FN_SLL, `FN_SRL, `FN_SRA,
                                    `FN_SLLV, `FN_SRLV, `FN_SRAV, `FN_MFHI, `FN_MFLO,
                                    `FN_JALR};
        dec_o.regjump    = funct inside {`FN_JR, `FN_JALR};
        dec_o.jalr       = funct == `FN_JALR;
        dec_o.mult_div   = funct inside {`FN_MTHI, `FN_MTLO, `FN_MULT, `FN_MULTU,
                                         `FN_DIV, `FN_DIVU};
        dec_o.md_signed  = funct inside {`FN_MULT, `FN_DIV};
        dec_o.hitoreg    = funct == `FN_MFHI;
        dec_o.lotoreg    = funct == `FN_MFLO;
        dec_o.branchlink = rt inside {`RT_BLTZAL, `RT_BGEZAL};

        case (funct)
            `FN_MTLO:            dec_o.md_op = ctrl_pkg::MD_MTLO;
            `FN_MULT, `FN_MULTU: dec_o.md_op = ctrl_pkg::MD_MULT;
            `FN_DIV, `FN_DIVU:   dec_o.md_op = ctrl_pkg::MD_DIV;
            default:             dec_o.md_op = ctrl_pkg::MD_MTHI;   // MTHI and the rest
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/opcode_decoder.sv
// opcode decoder
`timescale 1ns/10ps
`default_nettype none

`include "ctrl_macros.svh"

module opcode_decoder (
    input  logic [`CTRL_OPC_W-1:0] opcode,
    opc_dec_if.dec                 dec_o
);

    always_comb begin
        dec_o.is_rtype   = 1'b0;
        dec_o.is_load    = 1'b0;
        dec_o.is_store   = 1'b0;
        dec_o.is_regimm  = 1'b0;
        dec_o.writes_reg = 1'b0;
        dec_o.store_byte = 1'b0;
        dec_o.store_half = 1'b0;
        dec_o.alu_op     = ctrl_pkg::ALU_ADD;
        dec_o.alu_src    = 1'b0;
        dec_o.signed_imm = 1'b0;
        dec_o.jump       = 1'b0;
        dec_o.branch     = 1'b0;
        dec_o.regdst     = 1'b0;
        dec_o.memtoreg   = 1'b0;
        dec_o.link       = 1'b0;
        dec_o.loadimmed  = 1'b0;
        dec_o.extend_op  = ctrl_pkg::EXT_NONE;

        case (opcode)
            `OPC_RTYPE: begin
                dec_o.is_rtype = 1'b1;
                dec_o.alu_op   = ctrl_pkg::ALU_FUNCT;
                dec_o.regdst   = 1'b1;                       // write to rd
            end
            `OPC_ADDIU, `OPC_SLTI, `OPC_SLTIU, `OPC_ANDI, `OPC_ORI, `OPC_XORI: begin
                dec_o.alu_src    = 1'b1;
                dec_o.writes_reg = 1'b1;
                dec_o.signed_imm = opcode == `OPC_SLTI;
                case (opcode)
                    `OPC_SLTI:  dec_o.alu_op = ctrl_pkg::ALU_SLT;
                    `OPC_SLTIU: dec_o.alu_op = ctrl_pkg::ALU_SLTU;
                    `OPC_ANDI:  dec_o.alu_op = ctrl_pkg::ALU_AND;
                    `OPC_ORI:   dec_o.alu_op = ctrl_pkg::ALU_OR;
                    `OPC_XORI:  dec_o.alu_op = ctrl_pkg::ALU_XOR;
                    default:    dec_o.alu_op = ctrl_pkg::ALU_ADD;   // ADDIU
                endcase
            end
            `OPC_LUI: begin
                dec_o.alu_src    = 1'b1;
                dec_o.writes_reg = 1'b1;
                dec_o.loadimmed  = 1'b1;
            end
            `OPC_BEQ: begin
                dec_o.branch = 1'b1;
                dec_o.alu_op = ctrl_pkg::ALU_SUB_EQ;
            end
            `OPC_BNE: begin
                dec_o.branch = 1'b1;
                dec_o.alu_op = ctrl_pkg::ALU_NE;
            end
            `OPC_BGTZ, `OPC_BLEZ, `OPC_REGIMM: begin
                dec_o.branch    = 1'b1;
                dec_o.alu_src   = 1'b1;
                dec_o.is_regimm = opcode == `OPC_REGIMM;
                case (opcode)
                    `OPC_BGTZ: dec_o.alu_op = ctrl_pkg::ALU_GTZ;
                    `OPC_BLEZ: dec_o.alu_op = ctrl_pkg::ALU_LEZ;
                    default:   dec_o.alu_op = ctrl_pkg::ALU_LTZ;    // rt picks the form
                endcase
            end
            `OPC_LB, `OPC_LBU, `OPC_LH, `OPC_LHU, `OPC_LW: begin
                dec_o.is_load    = 1'b1;
                dec_o.alu_src    = 1'b1;                     // base plus offset
                dec_o.writes_reg = 1'b1;
                case (opcode)
                    `OPC_LB:  dec_o.extend_op = ctrl_pkg::EXT_BYTE_S;
                    `OPC_LBU: dec_o.extend_op = ctrl_pkg::EXT_BYTE_U;
                    `OPC_LH:  dec_o.extend_op = ctrl_pkg::EXT_HALF_S;
                    `OPC_LHU: dec_o.extend_op = ctrl_pkg::EXT_HALF_U;
                    default:  dec_o.memtoreg  = 1'b1;         // LW
                endcase
            end
            `OPC_SB, `OPC_SH, `OPC_SW: begin
                dec_o.is_store   = 1'b1;
                dec_o.alu_src    = 1'b1;
                dec_o.regdst     = 1'b1;
                dec_o.store_byte = opcode == `OPC_SB;
                dec_o.store_half = opcode == `OPC_SH;
            end
            `OPC_J: begin
                dec_o.jump = 1'b1;
            end
            `OPC_JAL: begin
                dec_o.jump       = 1'b1;
                dec_o.link       = 1'b1;                     // return address to r31
                dec_o.writes_reg = 1'b1;
            end
            default: ;                                       // unknown opcode stays inactive
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/ctrl_ifs.sv
// decoder result interfaces
`timescale 1ns/10ps
`default_nettype none

interface opc_dec_if;
    logic                  is_rtype;
    logic                  is_load;
    logic                  is_store;
    logic                  is_regimm;
    logic                  writes_reg;  // opcode writes rt or r31 in exec2
    logic                  store_byte;
    logic                  store_half;
    ctrl_pkg::alu_op_t     alu_op;
    logic                  alu_src;
    logic                  signed_imm;
    logic                  jump;
    logic                  branch;
    logic                  regdst;
    logic                  memtoreg;
    logic                  link;
    logic                  loadimmed;
    ctrl_pkg::ext_op_t     extend_op;

    modport dec (output is_rtype, is_load, is_store, is_regimm, writes_reg, store_byte,
                 store_half, alu_op, alu_src, signed_imm, jump, branch, regdst, memtoreg,
                 link, loadimmed, extend_op);
    modport seq (input is_rtype, is_load, is_store, is_regimm, writes_reg, store_byte,
                 store_half, alu_op, alu_src, signed_imm, jump, branch, regdst, memtoreg,
                 link, loadimmed, extend_op);
endinterface

interface fn_dec_if;
    logic              arith;       // funct writes rd
    logic              regjump;
    logic              jalr;
    logic              mult_div;
    logic              md_signed;
    ctrl_pkg::md_op_t  md_op;
    logic              hitoreg;
    logic              lotoreg;
    logic              branchlink;  // REGIMM link form

    modport dec (output arith, regjump, jalr, mult_div, md_signed, md_op, hitoreg, lotoreg,
                 branchlink);
    modport seq (input arith, regjump, jalr, mult_div, md_signed, md_op, hitoreg, lotoreg,
                 branchlink);
endinterface

`default_nettype wire

// File: hdl/ctrl_pkg.sv
// control unit types
`default_nettype none

`include "ctrl_macros.svh"

package ctrl_pkg;

    typedef struct packed {
        logic [`CTRL_OPC_W-1:0] opcode;
        logic [`CTRL_REG_W-1:0] rs;
        logic [`CTRL_REG_W-1:0] rt;
        logic [`CTRL_REG_W-1:0] rd;
        logic [`CTRL_REG_W-1:0] shamt;
        logic [`CTRL_FN_W-1:0]  funct;
    } r_fields_t;

    typedef struct packed {
        logic [`CTRL_OPC_W-1:0] opcode;
        logic [`CTRL_REG_W-1:0] rs;
        logic [`CTRL_REG_W-1:0] rt;
        logic [`CTRL_IMM_W-1:0] imm;
    } i_fields_t;

    // same word seen as R-format or I-format
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_word_t;

    typedef logic [`CTRL_ST_W-1:0] state_t;

    typedef enum logic [`CTRL_ALU_W-1:0] {
        ALU_ADD    = `ALU_ADD,
        ALU_SUB_EQ = `ALU_SUB_EQ,
        ALU_FUNCT  = `ALU_FUNCT,   // ALU decodes funct itself
        ALU_AND    = `ALU_AND,
        ALU_OR     = `ALU_OR,
        ALU_XOR    = `ALU_XOR,
        ALU_SLT    = `ALU_SLT,
        ALU_NE     = `ALU_NE,
        ALU_GTZ    = `ALU_GTZ,
        ALU_LEZ    = `ALU_LEZ,
        ALU_LTZ    = `ALU_LTZ,
        ALU_SLTU   = `ALU_SLTU
    } alu_op_t;

    typedef enum logic [`CTRL_EXT_W-1:0] {
        EXT_NONE   = `EXT_NONE,
        EXT_HALF_U = `EXT_HALF_U,
        EXT_HALF_S = `EXT_HALF_S,
        EXT_BYTE_U = `EXT_BYTE_U,
        EXT_BYTE_S = `EXT_BYTE_S
    } ext_op_t;

    typedef enum logic [1:0] {
        MD_MTHI = 2'b00,
        MD_MTLO = 2'b01,
        MD_MULT = 2'b10,
        MD_DIV  = 2'b11
    } md_op_t;

endpackage

`default_nettype wire

// File: hdl/ctrl_macros.svh
// control unit constants
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

`define CTRL_WORD_W 32
`define CTRL_OPC_W  6
`define CTRL_FN_W   6
`define CTRL_REG_W  5
`define CTRL_IMM_W  16
`define CTRL_ST_W   4
`define CTRL_ALU_W  4
`define CTRL_EXT_W  3

// opcodes
`define OPC_RTYPE  6'b000000
`define OPC_REGIMM 6'b000001
`define OPC_J      6'b000010
`define OPC_JAL    6'b000011
`define OPC_BEQ    6'b000100
`define OPC_BNE    6'b000101
`define OPC_BLEZ   6'b000110
`define OPC_BGTZ   6'b000111
`define OPC_ADDIU  6'b001001
`define OPC_SLTI   6'b001010
`define OPC_SLTIU  6'b001011
`define OPC_ANDI   6'b001100
`define OPC_ORI    6'b001101
`define OPC_XORI   6'b001110
`define OPC_LUI    6'b001111
`define OPC_LB     6'b100000
`define OPC_LH     6'b100001
`define OPC_LW     6'b100011
`define OPC_LBU    6'b100100
`define OPC_LHU    6'b100101
`define OPC_SB     6'b101000
`define OPC_SH     6'b101001
`define OPC_SW     6'b101011

// R-format funct codes
`define FN_SLL   6'b000000
`define FN_SRL   6'b000010
`define FN_SRA   6'b000011
`define FN_SLLV  6'b000100
`define FN_SRLV  6'b000110
`define FN_SRAV  6'b000111
`define FN_JR    6'b001000
`define FN_JALR  6'b001001
`define FN_MFHI  6'b010000
`define FN_MTHI  6'b010001
`define FN_MFLO  6'b010010
`define FN_MTLO  6'b010011
`define FN_MULT  6'b011000
`define FN_MULTU 6'b011001
`define FN_DIV   6'b011010
`define FN_DIVU  6'b011011
`define FN_ADDU  6'b100001
`define FN_SUBU  6'b100011
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_XOR   6'b100110
`define FN_SLT   6'b101010
`define FN_SLTU  6'b101011

// REGIMM rt codes with link
`define RT_BLTZAL 5'b10000
`define RT_BGEZAL 5'b10001

// sequencer states
`define ST_HALT   4'd0
`define ST_FETCH  4'd1
`define ST_DECODE 4'd2
`define ST_EXEC1  4'd3
`define ST_EXEC2  4'd4

// ALU op codes
`define ALU_ADD    4'b0000
`define ALU_SUB_EQ 4'b0001
`define ALU_FUNCT  4'b0010
`define ALU_AND    4'b0100
`define ALU_OR     4'b0101
`define ALU_XOR    4'b0110
`define ALU_SLT    4'b0111
`define ALU_NE     4'b1000
`define ALU_GTZ    4'b1001
`define ALU_LEZ    4'b1010
`define ALU_LTZ    4'b1011
`define ALU_SLTU   4'b1100

// load extend codes
`define EXT_NONE   3'b000
`define EXT_HALF_U 3'b100
`define EXT_HALF_S 3'b101
`define EXT_BYTE_U 3'b110
`define EXT_BYTE_S 3'b111

`endif
